// ==== Bender.yml ====
package:
  name: ccu

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/ccuPkg.sv
      - hdl/cfgSlotIf.sv
      - hdl/isaLoader.sv
      - hdl/isaBuffer.sv
      - hdl/isaDecoder.sv
      - hdl/cfgSlot.sv
      - hdl/netSequencer.sv
      - hdl/ccuTop.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - bench/ccuTb.sv

// ==== all.f ====
+incdir+hdl
hdl/ccuPkg.sv
hdl/cfgSlotIf.sv
hdl/isaLoader.sv
hdl/isaBuffer.sv
hdl/isaDecoder.sv
hdl/cfgSlot.sv
hdl/netSequencer.sv
hdl/ccuTop.sv
bench/ccuTb.sv

// ==== bench/ccuTb.sv ====
// CCU testbench
// Directed tests through the off-chip instruction port, with one modeled
// engine per configuration slot that acks after a random delay

`default_nettype none

`include "ccu_macros.svh"

module ccuTb import ccuPkg::*; ();

    localparam int NUM_INSTR    = 22;                  // Words sent over all tests
    localparam int WATCHDOG_CYC = 200 * NUM_INSTR + 20;

    logic                                clk;
    logic                                rst_n;
    logic                                start;
    logic [`CCU_ISA_IN_W-1:0]            isaDat;
    logic                                isaVld;
    wire                                 netDone;
    wire                                 isaRdy;
    freeCntT                             isaReqNum;
    wire  [`CCU_NUM_ENGINES-1:0]         cfgReq;
    wire  [`CCU_NUM_ENGINES-1:0]         cfgAck;
    cfgWordT [`CCU_NUM_ENGINES-1:0]      cfgData;

    integer  seed = 24035;
    int      ackMax;
    int      cycle = 0;
    int      doneCnt;
    int      doneCyc;
    isaWordT prog [$];
    cfgWordT expQ [`CCU_NUM_ENGINES][$];
    cfgWordT rxQ [`CCU_NUM_ENGINES][$];
    int      reqCyc [`CCU_NUM_ENGINES][$];     // Cycle each handshake started

    ccuTop ccuTop_i (
        .clk(clk), .rst_n(rst_n), .start(start), .netDone(netDone),
        .isaDat(isaDat), .isaVld(isaVld), .isaRdy(isaRdy), .isaReqNum(isaReqNum),
        .cfgReq(cfgReq), .cfgAck(cfgAck), .cfgData(cfgData)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    always @(negedge clk) begin
        if (netDone === 1'b1) begin
            doneCnt = doneCnt + 1;
            doneCyc = cycle;
        end
    end

    // ==============================
    // Reporting
    // ==============================
    task automatic stopWithFail(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic checkEq(input string what, input logic [127:0] got, input logic [127:0] exp);
        if (got !== exp) begin
            stopWithFail($sformatf("[FAIL] t=%0t %s: got %0h, expected %0h",
                                   $time, what, got, exp));
        end
    endtask

    function automatic int pickDelay();
        return 1 + ($unsigned($random(seed)) % ackMax);
    endfunction

    // ==============================
    // Engine models
    // ==============================
    for (genvar e = 0; e < `CCU_NUM_ENGINES; e++) begin : gEng
        logic    ack;
        cfgWordT seen;
        int      fallCyc;

        assign cfgAck[e] = ack;

        initial begin
            ack     = 1'b0;
            fallCyc = 0;
            forever begin
                @(negedge clk);
                if (cfgReq[e] === 1'b1) begin
                    seen = cfgData[e];
                    rxQ[e].push_back(seen);
                    reqCyc[e].push_back(cycle);
                    repeat (pickDelay()) begin
                        @(negedge clk);
                        checkEq($sformatf("engine %0d data held", e), cfgData[e], seen);
                    end
                    ack = 1'b1;
                    while (cfgReq[e]) begin
                        checkEq($sformatf("engine %0d data held", e), cfgData[e], seen);
                        @(negedge clk);
                    end
                    repeat (pickDelay()) @(negedge clk);
                    ack     = 1'b0;
                    fallCyc = cycle;     // netDone timing is measured from here
                end
            end
        end
    end

    // ==============================
    // Program building and running
    // ==============================
    function automatic isaWordT netWord(input layerCntT n);
        isaWordT w;
        w = '0;
        w[7:0] = OP_NET;
        w[8 +: `CCU_LAYER_W] = n;
        return w;
    endfunction

    task automatic addCfg(input opCodeE op, input cfgWordT payload);
        isaWordT w;
        w = '0;
        w[7:0] = op;
        w[8 +: `CCU_CFG_W] = payload;
        prog.push_back(w);
        expQ[int'(op) - 1].push_back(payload);   // Slot index is opcode minus one
    endtask

    task automatic clearProgram();
        prog.delete();
        for (int e = 0; e < `CCU_NUM_ENGINES; e++) begin
            expQ[e].delete();
            rxQ[e].delete();
            reqCyc[e].delete();
        end
    endtask

    task automatic runNet();
        isaWordT pad;
        if (prog.size() % 2 != 0) begin
            pad = '0;
            pad[7:0] = 8'hFF;             // Unknown opcode, discarded
            prog.push_back(pad);
        end
        doneCnt = 0;
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        for (int i = 0; i < prog.size(); i += 2) begin
            isaDat = {prog[i + 1], prog[i]};
            isaVld = 1'b1;
            while (!isaRdy) @(negedge clk);
            @(negedge clk);               // Beat taken on the posedge in between
        end
        isaVld = 1'b0;
        while (doneCnt == 0) @(negedge clk);
        repeat (10) @(negedge clk);
        checkEq("netDone pulse count", doneCnt, 1);
        checkEq("isaRdy after netDone", isaRdy, 1'b0);
        for (int e = 0; e < `CCU_NUM_ENGINES; e++) begin
            checkEq($sformatf("engine %0d payload count", e), rxQ[e].size(), expQ[e].size());
            for (int i = 0; i < expQ[e].size(); i++) begin
                checkEq($sformatf("engine %0d payload %0d", e, i), rxQ[e][i], expQ[e][i]);
            end
        end
    endtask

    // ==============================
    // Tests
    // ==============================
    task automatic testReset();
        checkEq("isaRdy after reset", isaRdy, 1'b0);
        checkEq("cfgReq after reset", cfgReq, '0);
        checkEq("netDone after reset", netDone, 1'b0);
        checkEq("isaReqNum after reset", isaReqNum, `CCU_ISA_DEPTH);
    endtask

    task automatic testSingleLayer();
        clearProgram();
        ackMax = 2;
        prog.push_back(netWord(1));
        addCfg(OP_CONV, 64'h0123_4567_89AB_CDEF);
        runNet();
        checkEq("netDone after ack 0 falls", doneCyc - gEng[0].fallCyc, 2);
    endtask

    task automatic testRouting();
        clearProgram();
        ackMax = 3;
        prog.push_back(netWord(3));
        addCfg(OP_POOL, 64'hAAAA_0000_1111_2222);
        addCfg(OP_CTR,  64'hBBBB_3333_4444_5555);
        addCfg(OP_CONV, 64'hCCCC_6666_7777_8888);
        runNet();
    endtask

    task automatic testOrder();
        clearProgram();
        ackMax = 10;                       // Slow engine 0 stalls the decoder
        prog.push_back(netWord(4));
        addCfg(OP_CONV, 64'h1000_0000_0000_0001);
        addCfg(OP_CONV, 64'h2000_0000_0000_0002);
        addCfg(OP_CONV, 64'h3000_0000_0000_0003);
        addCfg(OP_POOL, 64'h4000_0000_0000_0004);
        runNet();
        checkEq("pool waits for third conv", reqCyc[1][0] > reqCyc[0][2], 1'b1);
    endtask

    task automatic testRandom();
        int      k;
        cfgWordT payload;
        clearProgram();
        ackMax = 12;
        prog.push_back(netWord(8));
        for (int i = 0; i < 8; i++) begin
            k       = 1 + ($unsigned($random(seed)) % 3);
            payload = {$random(seed), $random(seed)};
            addCfg(opCodeE'(k), payload);
        end
        runNet();
    endtask

    initial begin
        rst_n  = 1'b0;
        start  = 1'b0;
        isaDat = '0;
        isaVld = 1'b0;
        ackMax = 2;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        testReset();
        testSingleLayer();
        testRouting();
        testOrder();
        testRandom();
        $display("Simulation finished: PASS");
        $finish;
    end

    // Bounded by the number of words sent
    initial begin
        repeat (WATCHDOG_CYC) @(posedge clk);
        stopWithFail($sformatf("Watchdog expired after %0d cycles, the DUT stopped responding",
                               WATCHDOG_CYC));
    end

endmodule

`default_nettype wire

// ==== hdl/ccuPkg.sv ====
// CCU package
// Instruction, configuration and counter types, opcodes and sequencer states

`default_nettype none

`include "ccu_macros.svh"

package ccuPkg;

    typedef logic [`CCU_ISA_W-1:0]   isaWordT;
    typedef logic [`CCU_CFG_W-1:0]   cfgWordT;
    typedef logic [`CCU_LAYER_W-1:0] layerCntT;
    typedef logic [$clog2(`CCU_ISA_DEPTH + 1)-1:0] freeCntT;  // Must reach DEPTH itself

    // Opcode lives in bits 7..0 of every word
    typedef enum logic [7:0] {
        OP_NET  = 8'd0,
        OP_CONV = 8'd1,
        OP_POOL = 8'd2,
        OP_CTR  = 8'd3
    } opCodeE;

    typedef enum logic [1:0] {SEQ_IDLE, SEQ_RUN, SEQ_FNH} seqStateE;

endpackage

`default_nettype wire

// ==== hdl/ccuTop.sv ====
// CCU top level
// Instruction loader, buffer and decoder feeding three engine slots,
// with the network sequencer tracking layer completion

`default_nettype none

`include "ccu_macros.svh"

module ccuTop import ccuPkg::*; (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           start,
    output logic                           netDone,
    input  logic [`CCU_ISA_IN_W-1:0]       isaDat,
    input  logic                           isaVld,
    output logic                           isaRdy,
    output freeCntT                        isaReqNum,
    output logic [`CCU_NUM_ENGINES-1:0]    cfgReq,
    input  logic [`CCU_NUM_ENGINES-1:0]    cfgAck,
    output cfgWordT [`CCU_NUM_ENGINES-1:0] cfgData
);

    logic     running;
    logic     wrEn;
    isaWordT  wrWord;
    freeCntT  freeCnt;
    logic     rdEn;
    isaWordT  rdWord;
    logic     empty;
    logic     layerLoad;
    layerCntT layerCnt;

    cfgSlotIf slotIf [`CCU_NUM_ENGINES] ();

    assign isaReqNum = freeCnt;

    // ==============================
    // Instruction path
    // ==============================
    isaLoader isaLoader_i (
        .clk(clk), .rst_n(rst_n), .isaDat(isaDat), .isaVld(isaVld), .isaRdy(isaRdy),
        .running(running), .freeCnt(freeCnt), .wrEn(wrEn), .wrWord(wrWord)
    );

    isaBuffer isaBuffer_i (
        .clk(clk), .rst_n(rst_n), .running(running), .wrEn(wrEn), .wrWord(wrWord),
        .rdEn(rdEn), .rdWord(rdWord), .empty(empty), .freeCnt(freeCnt)
    );

    isaDecoder isaDecoder_i (
        .clk(clk), .rst_n(rst_n), .running(running), .empty(empty), .rdEn(rdEn),
        .rdWord(rdWord), .layerLoad(layerLoad), .layerCnt(layerCnt), .slots(slotIf)
    );

    // ==============================
    // Engines and sequencing
    // ==============================
    for (genvar g = 0; g < `CCU_NUM_ENGINES; g++) begin : gSlot   // 0 conv, 1 pool, 2 ctr
        cfgSlot cfgSlot_i (
            .clk(clk), .rst_n(rst_n), .port(slotIf[g]),
            .cfgReq(cfgReq[g]), .cfgAck(cfgAck[g]), .cfgData(cfgData[g])
        );
    end

    netSequencer netSequencer_i (
        .clk(clk), .rst_n(rst_n), .start(start), .layerLoad(layerLoad),
        .layerCnt(layerCnt), .slots(slotIf), .running(running), .netDone(netDone)
    );

endmodule

`default_nettype wire

// ==== hdl/ccu_macros.svh ====
// CCU width and depth definitions
// Shared by the package, the slot interface and the RTL blocks

`ifndef CCU_MACROS_SVH
`define CCU_MACROS_SVH

// Off-chip instruction beat
`define CCU_ISA_IN_W     256
// On-chip instruction word, two per beat
`define CCU_ISA_W        128
`define CCU_ISA_DEPTH    16

// Engine side
`define CCU_NUM_ENGINES  3
`define CCU_CFG_W        64
`define CCU_LAYER_W      20

`endif

// ==== hdl/cfgSlot.sv ====
// Engine configuration slot
// Latches one configuration word and delivers it to its engine over a
// four-phase req/ack handshake

`default_nettype none

module cfgSlot import ccuPkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    cfgSlotIf.slot  port,
    output logic    cfgReq,
    input  logic    cfgAck,
    output cfgWordT cfgData
);

    localparam logic [1:0] PH_IDLE = 2'd0;
    localparam logic [1:0] PH_REQ  = 2'd1;   // Req high, waiting for ack
    localparam logic [1:0] PH_REL  = 2'd2;   // Req low, waiting for ack to drop

    logic [1:0] phase;
    logic       doneQ;

    assign cfgReq    = (phase == PH_REQ);
    assign port.busy = (phase != PH_IDLE);
    assign port.done = doneQ;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase <= PH_IDLE;
            doneQ <= 1'b0;
        end else begin
            doneQ <= 1'b0;
            case (phase)
                PH_IDLE: if (port.load) phase <= PH_REQ;
                PH_REQ:  if (cfgAck) phase <= PH_REL;
                PH_REL: begin
                    if (!cfgAck) begin
                        phase <= PH_IDLE;
                        doneQ <= 1'b1;       // Busy drops in the same cycle
                    end
                end
                default: phase <= PH_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (port.load) cfgData <= port.cfg;
    end

    // Engine samples data any time while req is up
    aDataStable: assert property (@(posedge clk) disable iff (!rst_n)
        cfgReq |=> $stable(cfgData));

endmodule

`default_nettype wire

// ==== hdl/cfgSlotIf.sv ====
// Configuration slot link
// Decoder loads a word into a slot, sequencer watches the slot finish

`default_nettype none

`include "ccu_macros.svh"

interface cfgSlotIf;

    logic                  load;   // One cycle, only while busy is low
    logic [`CCU_CFG_W-1:0] cfg;
    logic                  busy;
    logic                  done;   // One cycle at end of engine handshake

    modport dec  (output load, cfg, input busy);
    modport slot (input load, cfg, output busy, done);
    modport seq  (input done);

endinterface

`default_nettype wire

// ==== hdl/isaBuffer.sv ====
// Instruction buffer
// 16-entry circular FIFO with a registered read port and a free-entry count,
// emptied whenever no network is running

`default_nettype none

`include "ccu_macros.svh"

module isaBuffer import ccuPkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    running,
    input  logic    wrEn,
    input  isaWordT wrWord,
    input  logic    rdEn,
    output isaWordT rdWord,
    output logic    empty,
    output freeCntT freeCnt
);

    localparam int AW = $clog2(`CCU_ISA_DEPTH);

    isaWordT        mem [`CCU_ISA_DEPTH];
    logic [AW-1:0]  wrPtr;
    logic [AW-1:0]  rdPtr;
    logic           doWr;
    logic           doRd;
    logic           full;

    assign doWr  = wrEn && running;
    assign doRd  = rdEn && running;
    assign empty = (freeCnt == freeCntT'(`CCU_ISA_DEPTH));
    assign full  = (freeCnt == '0);

    // ==============================
    // Pointers and count
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wrPtr   <= '0;
            rdPtr   <= '0;
            freeCnt <= freeCntT'(`CCU_ISA_DEPTH);
        end else if (!running) begin
            wrPtr   <= '0;                          // Flush, also on the start cycle
            rdPtr   <= '0;
            freeCnt <= freeCntT'(`CCU_ISA_DEPTH);
        end else begin
            if (doWr) wrPtr <= wrPtr + 1'b1;
            if (doRd) rdPtr <= rdPtr + 1'b1;
            case ({doWr, doRd})
                2'b10:   freeCnt <= freeCnt - 1'b1;
                2'b01:   freeCnt <= freeCnt + 1'b1;
                default: freeCnt <= freeCnt;       // None or both
            endcase
        end
    end

    // Storage and registered read
    always_ff @(posedge clk) begin
        if (doWr) mem[wrPtr] <= wrWord;
        if (doRd) rdWord <= mem[rdPtr];
    end

    aNoReadEmpty: assert property (@(posedge clk) disable iff (!rst_n) doRd |-> !empty);
    aNoWriteFull: assert property (@(posedge clk) disable iff (!rst_n) doWr |-> !full);

endmodule

`default_nettype wire

// ==== hdl/isaDecoder.sv ====
// Instruction decoder
// Pops one word at a time, loads NET layer counts into the sequencer and
// hands engine configurations to their slots in program order

`default_nettype none

`include "ccu_macros.svh"

module isaDecoder import ccuPkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     running,
    input  logic     empty,
    output logic     rdEn,
    input  isaWordT  rdWord,
    output logic     layerLoad,
    output layerCntT layerCnt,
    cfgSlotIf.dec    slots [`CCU_NUM_ENGINES]
);

    localparam int IW = $clog2(`CCU_NUM_ENGINES);

    logic                        wordVld;   // rdWord holds an undispatched word
    opCodeE                      opCode;
    logic                        tgtVld;
    logic [IW-1:0]               tgtIdx;
    logic [`CCU_NUM_ENGINES-1:0] busyVec;
    logic [`CCU_NUM_ENGINES-1:0] loadVec;
    logic                        dispatch;

    assign opCode = opCodeE'(rdWord[7:0]);

    // Engine opcode to slot index
    always_comb begin
        tgtVld = 1'b0;
        tgtIdx = '0;
        case (opCode)
            OP_CONV: begin tgtVld = 1'b1; tgtIdx = IW'(0); end
            OP_POOL: begin tgtVld = 1'b1; tgtIdx = IW'(1); end
            OP_CTR:  begin tgtVld = 1'b1; tgtIdx = IW'(2); end
            default: ;                       // NET or unknown
        endcase
    end

    // A busy target stalls this word and everything behind it
    assign dispatch  = running && wordVld && (!tgtVld || !busyVec[tgtIdx]);
    assign rdEn      = running && !empty && !wordVld;
    assign layerLoad = dispatch && (opCode == OP_NET);
    assign layerCnt  = rdWord[8 +: `CCU_LAYER_W];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wordVld <= 1'b0;
        end else if (!running) begin
            wordVld <= 1'b0;
        end else if (rdEn) begin
            wordVld <= 1'b1;        // Word shows up next cycle
        end else if (dispatch) begin
            wordVld <= 1'b0;
        end
    end

    // ==============================
    // Slot links
    // ==============================
    for (genvar i = 0; i < `CCU_NUM_ENGINES; i++) begin : gLink
        assign busyVec[i]   = slots[i].busy;
        assign loadVec[i]   = dispatch && tgtVld && (tgtIdx == IW'(i));
        assign slots[i].load = loadVec[i];
        assign slots[i].cfg  = rdWord[8 +: `CCU_CFG_W];
    end

endmodule

`default_nettype wire

// ==== hdl/isaLoader.sv ====
// Instruction loader
// Takes 256-bit beats from the off-chip port and writes them to the
// instruction buffer as two 128-bit words, low half first

`default_nettype none

`include "ccu_macros.svh"

module isaLoader import ccuPkg::*; (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [`CCU_ISA_IN_W-1:0] isaDat,
    input  logic                    isaVld,
    output logic                    isaRdy,
    input  logic                    running,
    input  freeCntT                 freeCnt,
    output logic                    wrEn,
    output isaWordT                 wrWord
);

    localparam logic [1:0] LD_NONE = 2'd0;
    localparam logic [1:0] LD_LOW  = 2'd1;
    localparam logic [1:0] LD_HIGH = 2'd2;

    logic [1:0]               phase;
    logic [`CCU_ISA_IN_W-1:0] beat;

    // Both halves must fit before a beat is taken
    assign isaRdy = running && (phase == LD_NONE) && (freeCnt >= freeCntT'(2));
    assign wrEn   = running && (phase != LD_NONE);
    assign wrWord = (phase == LD_HIGH) ? beat[`CCU_ISA_W +: `CCU_ISA_W] : beat[0 +: `CCU_ISA_W];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase <= LD_NONE;
        end else if (!running) begin
            phase <= LD_NONE;      // Drop anything half written
        end else begin
            case (phase)
                LD_NONE: if (isaVld && isaRdy) phase <= LD_LOW;
                LD_LOW:  phase <= LD_HIGH;
                default: phase <= LD_NONE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (isaVld && isaRdy) beat <= isaDat;
    end

    // Writes only land in free space
    aWriteHasRoom: assert property (@(posedge clk) disable iff (!rst_n)
        wrEn |-> freeCnt != '0);

endmodule

`default_nettype wire

// ==== hdl/netSequencer.sv ====
// Network sequencer
// Runs one network from start, counts completed engine handshakes and
// flags the end when the count reaches the NET layer count

`default_nettype none

`include "ccu_macros.svh"

module netSequencer import ccuPkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     start,
    input  logic     layerLoad,
    input  layerCntT layerCnt,
    cfgSlotIf.seq    slots [`CCU_NUM_ENGINES],
    output logic     running,
    output logic     netDone
);

    localparam int SUM_W = $clog2(`CCU_NUM_ENGINES + 1);

    seqStateE                    state;
    layerCntT                    target;
    layerCntT                    doneCnt;
    layerCntT                    cntNext;
    logic [`CCU_NUM_ENGINES-1:0] doneVec;
    logic [SUM_W-1:0]            doneSum;
    logic                        lastLayer;

    for (genvar i = 0; i < `CCU_NUM_ENGINES; i++) begin : gDone
        assign doneVec[i] = slots[i].done;
    end

    // Several slots may finish together
    always_comb begin
        doneSum = '0;
        for (int k = 0; k < `CCU_NUM_ENGINES; k++) begin
            doneSum = doneSum + SUM_W'(doneVec[k]);
        end
    end

    assign cntNext   = doneCnt + layerCntT'(doneSum);
    assign lastLayer = (target != '0) && (cntNext == target);
    assign running   = (state == SEQ_RUN);
    assign netDone   = (state == SEQ_FNH);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= SEQ_IDLE;
            target  <= '0;
            doneCnt <= '0;
        end else begin
            case (state)
                SEQ_IDLE: begin
                    if (start) begin
                        state   <= SEQ_RUN;
                        target  <= '0;
                        doneCnt <= '0;
                    end
                end
                SEQ_RUN: begin
                    doneCnt <= cntNext;
                    if (layerLoad) target <= layerCnt;
                    if (lastLayer) state <= SEQ_FNH;
                end
                default: state <= SEQ_IDLE;    // Finish lasts one cycle
            endcase
        end
    end

endmodule

`default_nettype wire
